//--- source/idct_pkg.sv
// IDCT T stage shared package with SRAM and buffer types, controller states and the cosine matrix
package idct_pkg;

	// --------------------
	// Widths that carry a meaning
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;
	typedef logic signed [15:0] sample_t;
	typedef logic signed [15:0] coeff_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [4:0] pair_addr_t;
	typedef logic [5:0] block_idx_t;

	// SRAM command, a write when we_n is low
	typedef struct packed {
		sram_addr_t address;
		sram_data_t write_data;
		logic we_n;
	} sram_port_t;

	// Port A write of the sample buffer
	// Even sample of the pair sits in data[1], odd sample in data[0]
	typedef struct packed {
		pair_addr_t addr;
		sample_t [1:0] data;
		logic we;
	} pair_write_t;

	// Four T values of one row, for columns 4*col_half to 4*col_half+3
	typedef struct packed {
		acc_t [3:0] values;
		logic [2:0] row;
		logic col_half;
		logic last;
		logic valid;
	} t_group_t;

	typedef enum logic [1:0] {ctrl_idle, ctrl_fetch, ctrl_compute, ctrl_ack} ctrl_state_t;

	// Samples per row of the pre-IDCT plane
	localparam int plane_width = 320;

	// --------------------
	// Rows 0 to 3 of C, scaled by 2048
	// Row 7-k equals row k with odd columns negated
	localparam coeff_t cos_half [0:3][0:7] = '{
		'{16'sd1448, 16'sd2008, 16'sd1892, 16'sd1702, 16'sd1448, 16'sd1137, 16'sd783, 16'sd399},
		'{16'sd1448, 16'sd1702, 16'sd783, -16'sd399, -16'sd1448, -16'sd2008, -16'sd1892,
			-16'sd1137},
		'{16'sd1448, 16'sd1137, -16'sd783, -16'sd2008, -16'sd1448, 16'sd399, 16'sd1892,
			16'sd1702},
		'{16'sd1448, 16'sd399, -16'sd1892, -16'sd1137, 16'sd1448, 16'sd1702, -16'sd783,
			-16'sd2008}
	};

	// C[k][j] from the folded table
	function automatic coeff_t cos_coeff(input logic [2:0] k, input logic [2:0] j);
		logic [1:0] k_fold;
		coeff_t c;
		// 4..7 fold onto 3..0
		k_fold = k[2] ? ~k[1:0] : k[1:0];
		c = cos_half[k_fold][j];
		if (k[2] && j[0]) begin
			c = -c;
		end
		return c;
	endfunction

endpackage

//--- source/block_fetch.sv
// Block fetch, reads one 8x8 pre-IDCT block from SRAM and packs the samples in pairs
`timescale 1ns/1ps

module block_fetch #(
	parameter idct_pkg::sram_addr_t pre_idct_base = 18'd76800,
	parameter int sram_read_latency = 3
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic fetch_start,
	input idct_pkg::block_idx_t block_row,
	input idct_pkg::block_idx_t block_col,
	input idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_port_t fetch_cmd,
	output idct_pkg::pair_write_t pair_wr,
	output logic fetch_done
);

	// --------------------
	// Read issue side
	logic issuing;
	logic issue;
	logic [5:0] sample_cnt;
	idct_pkg::block_idx_t row_q;
	idct_pkg::block_idx_t col_q;
	idct_pkg::block_idx_t row_sel;
	idct_pkg::block_idx_t col_sel;
	logic [8:0] row_abs;
	logic [8:0] col_abs;
	idct_pkg::sram_addr_t next_addr;
	idct_pkg::sram_addr_t rd_addr_q;
	logic rd_issue;

	// Return side
	logic [sram_read_latency-1:0] ret_vld;
	logic ret_valid;
	logic ret_odd;
	idct_pkg::pair_addr_t pair_cnt;
	idct_pkg::sample_t even_q;
	logic pair_we_q;
	idct_pkg::pair_addr_t pair_addr_q;
	idct_pkg::sample_t [1:0] pair_data_q;
	logic done_q;

	// First read goes out right after fetch_start, so use the live coordinates then
	assign issue = fetch_start | issuing;
	assign row_sel = fetch_start ? block_row : row_q;
	assign col_sel = fetch_start ? block_col : col_q;

	// Plane row and column of the current sample
	assign row_abs = {row_sel, sample_cnt[5:3]};
	assign col_abs = {col_sel, sample_cnt[2:0]};
	assign next_addr = pre_idct_base
		+ idct_pkg::sram_addr_t'(idct_pkg::plane_width) * idct_pkg::sram_addr_t'(row_abs)
		+ idct_pkg::sram_addr_t'(col_abs);

	// Data for an address shows up sram_read_latency cycles after it is on the bus
	assign ret_valid = ret_vld[sram_read_latency-1];

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			issuing <= 1'b0;
			sample_cnt <= 6'd0;
			rd_issue <= 1'b0;
			ret_vld <= '0;
			ret_odd <= 1'b0;
			pair_cnt <= '0;
			pair_we_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			rd_issue <= issue;
			if (issue) begin
				// Counter wraps back to 0 after sample 63
				sample_cnt <= sample_cnt + 6'd1;
				issuing <= (sample_cnt != 6'd63);
			end
			// Reads in flight
			ret_vld[0] <= rd_issue;
			for (int i = 1; i < sram_read_latency; i++) begin
				ret_vld[i] <= ret_vld[i-1];
			end
			if (ret_valid) begin
				ret_odd <= ~ret_odd;
				if (ret_odd) begin
					pair_cnt <= pair_cnt + 5'd1;
				end
			end
			pair_we_q <= ret_valid & ret_odd;
			// Done once pair 31 is in the buffer
			done_q <= pair_we_q & (&pair_addr_q);
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (fetch_start) begin
			row_q <= block_row;
			col_q <= block_col;
		end
		if (issue) begin
			rd_addr_q <= next_addr;
		end
		if (ret_valid) begin
			if (!ret_odd) begin
				even_q <= idct_pkg::sample_t'(sram_read_data);
			end else begin
				pair_addr_q <= pair_cnt;
				pair_data_q <= {even_q, idct_pkg::sample_t'(sram_read_data)};
			end
		end
	end

	// Fetch only ever reads
	assign fetch_cmd = '{address: rd_addr_q, write_data: '0, we_n: 1'b1};
	assign pair_wr = '{addr: pair_addr_q, data: pair_data_q, we: pair_we_q};
	assign fetch_done = done_q;

endmodule

//--- source/sample_buffer.sv
// Sample buffer, dual-port RAM holding one 8x8 block as 32 sample pairs
`timescale 1ns/1ps

module sample_buffer (
	input logic CLOCK_50_I,
	input idct_pkg::pair_write_t pair_wr,
	input idct_pkg::pair_addr_t rd_addr,
	output idct_pkg::sample_t [1:0] rd_data
);

	// --------------------
	// One word per pair, depth follows the pair address width
	localparam int depth = 1 << $bits(idct_pkg::pair_addr_t);

	idct_pkg::sample_t [1:0] mem [0:depth-1];

	// Port A, write only
	always_ff @(posedge CLOCK_50_I) begin
		if (pair_wr.we) begin
			mem[pair_wr.addr] <= pair_wr.data;
		end
	end

	// Port B, registered read
	// data lags the address by one cycle
	always_ff @(posedge CLOCK_50_I) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- source/t_product_mac.sv
// T product MAC, computes T = S' x C with four multiply-accumulate lanes
`timescale 1ns/1ps

module t_product_mac (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic mac_start,
	output idct_pkg::pair_addr_t rd_addr,
	input idct_pkg::sample_t [1:0] rd_data,
	output idct_pkg::t_group_t t_group
);

	// --------------------
	// Address phase counters
	// pass[3:1] is the S' row, pass[0] the column half
	logic running;
	logic [3:0] pass_cnt;
	logic [2:0] cyc_cnt;

	// Data phase, one cycle behind the buffer address
	logic act_d;
	logic [3:0] pass_d;
	logic [2:0] cyc_d;

	// Lanes
	idct_pkg::sample_t sample_sel;
	idct_pkg::coeff_t coeff [4];
	idct_pkg::acc_t prod [4];
	idct_pkg::acc_t acc [4];

	// Output group
	idct_pkg::acc_t [3:0] grp_values;
	logic [2:0] grp_row;
	logic grp_half;
	logic grp_last;
	logic grp_valid;

	// Sample k of the row lives in pair k/2
	assign rd_addr = {pass_cnt[3:1], cyc_cnt[2:1]};

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			running <= 1'b0;
			pass_cnt <= 4'd0;
			cyc_cnt <= 3'd0;
			act_d <= 1'b0;
			pass_d <= 4'd0;
			cyc_d <= 3'd0;
			grp_valid <= 1'b0;
		end else begin
			if (mac_start) begin
				running <= 1'b1;
				pass_cnt <= 4'd0;
				cyc_cnt <= 3'd0;
			end else if (running) begin
				cyc_cnt <= cyc_cnt + 3'd1;
				if (cyc_cnt == 3'd7) begin
					pass_cnt <= pass_cnt + 4'd1;
					// Sixteen passes per block
					if (pass_cnt == 4'd15) begin
						running <= 1'b0;
					end
				end
			end
			act_d <= running;
			pass_d <= pass_cnt;
			cyc_d <= cyc_cnt;
			// One group per pass, the cycle after its last product
			grp_valid <= act_d & (&cyc_d);
		end
	end

	// --------------------
	// Multipliers
	always_comb begin
		// Even k in the upper half of the pair
		sample_sel = cyc_d[0] ? rd_data[0] : rd_data[1];
		for (int l = 0; l < 4; l++) begin
			// Lane l computes column 4*col_half + l
			coeff[l] = idct_pkg::cos_coeff(cyc_d, {pass_d[0], 2'(l)});
			prod[l] = idct_pkg::acc_t'(sample_sel) * idct_pkg::acc_t'(coeff[l]);
		end
	end

	// Accumulators restart on the first product of each pass
	always_ff @(posedge CLOCK_50_I) begin
		if (act_d) begin
			for (int l = 0; l < 4; l++) begin
				acc[l] <= (cyc_d == 3'd0) ? prod[l] : acc[l] + prod[l];
			end
			if (cyc_d == 3'd7) begin
				for (int l = 0; l < 4; l++) begin
					grp_values[l] <= acc[l] + prod[l];
				end
				grp_row <= pass_d[3:1];
				grp_half <= pass_d[0];
				grp_last <= &pass_d;
			end
		end
	end

	assign t_group = '{
		values: grp_values,
		row: grp_row,
		col_half: grp_half,
		last: grp_last,
		valid: grp_valid
	};

endmodule

//--- source/t_result_writer.sv
// T result writer, scales each T group by 1/256 and writes it to the SRAM T region
`timescale 1ns/1ps

module t_result_writer #(
	parameter idct_pkg::sram_addr_t t_base = 18'd146944
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input idct_pkg::t_group_t t_group,
	output idct_pkg::sram_port_t write_cmd,
	output logic write_done
);

	logic busy;
	logic [1:0] lane;
	idct_pkg::acc_t values_q [4];
	logic [2:0] row_q;
	logic half_q;
	logic last_q;
	idct_pkg::acc_t scaled;
	logic we_n_q;
	idct_pkg::sram_addr_t wr_addr_q;
	idct_pkg::sram_data_t wr_data_q;
	logic done_q;

	// Arithmetic shift keeps the sign
	assign scaled = values_q[lane] >>> 8;

	// --------------------
	// One word per cycle, four cycles per group
	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			busy <= 1'b0;
			lane <= 2'd0;
			we_n_q <= 1'b1;
			done_q <= 1'b0;
		end else begin
			if (t_group.valid) begin
				busy <= 1'b1;
				lane <= 2'd0;
			end else if (busy) begin
				lane <= lane + 2'd1;
				if (lane == 2'd3) begin
					busy <= 1'b0;
				end
			end
			we_n_q <= ~busy;
			// Marks the final word of the block while it is on the bus
			done_q <= busy & (lane == 2'd3) & last_q;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (t_group.valid) begin
			for (int l = 0; l < 4; l++) begin
				values_q[l] <= t_group.values[l];
			end
			row_q <= t_group.row;
			half_q <= t_group.col_half;
			last_q <= t_group.last;
		end
		if (busy) begin
			// Word offset is 8*row + 4*col_half + lane
			wr_addr_q <= t_base + idct_pkg::sram_addr_t'({row_q, half_q, lane});
			wr_data_q <= idct_pkg::sram_data_t'(scaled);
		end
	end

	assign write_cmd = '{address: wr_addr_q, write_data: wr_data_q, we_n: we_n_q};
	assign write_done = done_q;

endmodule

//--- source/idct_controller.sv
// IDCT T stage controller, req/ack handshake, phase sequencing and SRAM port select
`timescale 1ns/1ps

module idct_controller (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic req,
	output logic ack,
	output logic fetch_start,
	output logic mac_start,
	input logic fetch_done,
	input logic write_done,
	input idct_pkg::sram_port_t fetch_cmd,
	input idct_pkg::sram_port_t write_cmd,
	output idct_pkg::sram_port_t sram_cmd
);

	idct_pkg::ctrl_state_t state;

	// --------------------
	// State machine
	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			state <= idct_pkg::ctrl_idle;
		end else begin
			case (state)
				idct_pkg::ctrl_idle: begin
					// New block request
					if (req) begin
						state <= idct_pkg::ctrl_fetch;
					end
				end
				idct_pkg::ctrl_fetch: begin
					if (fetch_done) begin
						state <= idct_pkg::ctrl_compute;
					end
				end
				idct_pkg::ctrl_compute: begin
					// Last T word goes out in this cycle
					if (write_done) begin
						state <= idct_pkg::ctrl_ack;
					end
				end
				idct_pkg::ctrl_ack: begin
					// Hold ack until the requester drops req
					if (!req) begin
						state <= idct_pkg::ctrl_idle;
					end
				end
				default: begin
					state <= idct_pkg::ctrl_idle;
				end
			endcase
		end
	end

	// Start pulses last one cycle since the state moves on at the same edge
	assign fetch_start = (state == idct_pkg::ctrl_idle) & req;
	assign mac_start = (state == idct_pkg::ctrl_fetch) & fetch_done;
	assign ack = (state == idct_pkg::ctrl_ack);

	// --------------------
	// SRAM port owner
	always_comb begin
		// Nobody owns the port, keep it reading
		sram_cmd = '{address: '0, write_data: '0, we_n: 1'b1};
		case (state)
			idct_pkg::ctrl_fetch: sram_cmd = fetch_cmd;
			idct_pkg::ctrl_compute: sram_cmd = write_cmd;
			default: ;
		endcase
	end

endmodule

//--- source/idct_t_stage.sv
// IDCT T stage top, fetches an 8x8 block, computes T = S' x C and writes T back to SRAM
`timescale 1ns/1ps

module idct_t_stage #(
	parameter idct_pkg::sram_addr_t pre_idct_base = 18'd76800,
	parameter idct_pkg::sram_addr_t t_base = 18'd146944,
	parameter int sram_read_latency = 3
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic req,
	output logic ack,
	input idct_pkg::block_idx_t block_row,
	input idct_pkg::block_idx_t block_col,
	input idct_pkg::sram_data_t sram_read_data,
	output idct_pkg::sram_port_t sram_cmd
);

	// --------------------
	// Phase handshakes
	logic fetch_start;
	logic fetch_done;
	logic mac_start;
	logic write_done;

	// SRAM commands before the port select
	idct_pkg::sram_port_t fetch_cmd;
	idct_pkg::sram_port_t write_cmd;

	// Sample buffer ports and T groups
	idct_pkg::pair_write_t pair_wr;
	idct_pkg::pair_addr_t rd_addr;
	idct_pkg::sample_t [1:0] rd_data;
	idct_pkg::t_group_t t_group;

	idct_controller u_controller (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.req(req),
		.ack(ack),
		.fetch_start(fetch_start),
		.mac_start(mac_start),
		.fetch_done(fetch_done),
		.write_done(write_done),
		.fetch_cmd(fetch_cmd),
		.write_cmd(write_cmd),
		.sram_cmd(sram_cmd)
	);

	block_fetch #(
		.pre_idct_base(pre_idct_base),
		.sram_read_latency(sram_read_latency)
	) u_fetch (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.fetch_start(fetch_start),
		.block_row(block_row),
		.block_col(block_col),
		.sram_read_data(sram_read_data),
		.fetch_cmd(fetch_cmd),
		.pair_wr(pair_wr),
		.fetch_done(fetch_done)
	);

	sample_buffer u_buffer (
		.CLOCK_50_I(CLOCK_50_I),
		.pair_wr(pair_wr),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	t_product_mac u_mac (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.mac_start(mac_start),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.t_group(t_group)
	);

	t_result_writer #(
		.t_base(t_base)
	) u_writer (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.t_group(t_group),
		.write_cmd(write_cmd),
		.write_done(write_done)
	);

endmodule

//--- bench/sram_model.sv
// Behavioural SRAM with a fixed read latency and a log of every write it receives
`timescale 1ns/1ps

module sram_model #(
	parameter int read_latency = 3,
	parameter int log_depth = 1024
) (
	input logic CLOCK_50_I,
	input idct_pkg::sram_port_t sram_cmd,
	output idct_pkg::sram_data_t sram_read_data
);

	localparam int words = 1 << $bits(idct_pkg::sram_addr_t);

	// Storage
	// Filled by the testbench before the first request
	idct_pkg::sram_data_t mem [0:words-1];

	// Addresses on their way to the data bus
	idct_pkg::sram_addr_t addr_pipe [0:read_latency-1];

	// --------------------
	// Write log in bus order
	idct_pkg::sram_addr_t log_addr [0:log_depth-1];
	idct_pkg::sram_data_t log_data [0:log_depth-1];
	int log_count = 0;

	always @(posedge CLOCK_50_I) begin
		addr_pipe[0] <= sram_cmd.address;
		for (int i = 1; i < read_latency; i++) begin
			addr_pipe[i] <= addr_pipe[i-1];
		end
		if (!sram_cmd.we_n) begin
			mem[sram_cmd.address] <= sram_cmd.write_data;
			// Entries past the end are counted but not kept
			if (log_count < log_depth) begin
				log_addr[log_count] <= sram_cmd.address;
				log_data[log_count] <= sram_cmd.write_data;
			end
			log_count <= log_count + 1;
		end
	end

	// Data appears read_latency cycles after its address was on the bus
	assign sram_read_data = mem[addr_pipe[read_latency-1]];

endmodule

//--- bench/tb_idct_t_stage.sv
// Testbench for the IDCT T stage with random block requests and a T product model
`timescale 1ns/1ps

module tb_idct_t_stage;

	localparam idct_pkg::sram_addr_t pre_idct_base = 18'd76800;
	localparam idct_pkg::sram_addr_t t_base = 18'd146944;
	localparam int sram_read_latency = 3;
	localparam int plane_rows = 240;
	localparam int num_random_blocks = 12;
	localparam int cycles_per_request = 400;
	localparam int cycle_limit = num_random_blocks * cycles_per_request;

	logic CLOCK_50_I = 1'b0;
	logic Resetn;
	logic req;
	logic ack;
	idct_pkg::block_idx_t block_row;
	idct_pkg::block_idx_t block_col;
	idct_pkg::sram_data_t sram_read_data;
	idct_pkg::sram_port_t sram_cmd;

	// Error counts
	int value_errors = 0;
	int address_errors = 0;
	int handshake_errors = 0;
	int timeout_errors = 0;
	int cycle_count = 0;

	// Current request
	string test_name = "reset";
	int cur_row = 0;
	int cur_col = 0;
	int blk_row;
	int blk_col;
	int unsigned seed = 32'h8960;
	idct_pkg::sram_data_t expected_t [0:63];

	// Monitor state
	logic req_prev = 1'b0;
	logic ack_prev = 1'b0;
	logic req_seen = 1'b0;
	int read_count = 0;
	logic [63:0] read_mask = '0;
	int log_start = 0;
	int mon_idx;

	idct_t_stage #(
		.pre_idct_base(pre_idct_base),
		.t_base(t_base),
		.sram_read_latency(sram_read_latency)
	) DUT (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.req(req),
		.ack(ack),
		.block_row(block_row),
		.block_col(block_col),
		.sram_read_data(sram_read_data),
		.sram_cmd(sram_cmd)
	);

	sram_model #(
		.read_latency(sram_read_latency)
	) sram (
		.CLOCK_50_I(CLOCK_50_I),
		.sram_cmd(sram_cmd),
		.sram_read_data(sram_read_data)
	);

	// 4 ns period
	always #2 CLOCK_50_I = ~CLOCK_50_I;

	// --------------------
	// Address helpers
	function automatic idct_pkg::sram_addr_t sample_addr(input int row, input int col,
		input int r, input int k);
		return idct_pkg::sram_addr_t'(pre_idct_base
			+ idct_pkg::plane_width * (8 * row + r) + 8 * col + k);
	endfunction

	// Sample index inside the current block or -1
	function automatic int block_index(input idct_pkg::sram_addr_t addr);
		int offset;
		int prow;
		int pcol;
		if ($isunknown(addr) || addr < pre_idct_base) begin
			return -1;
		end
		offset = int'(addr) - int'(pre_idct_base);
		prow = offset / idct_pkg::plane_width;
		pcol = offset % idct_pkg::plane_width;
		if (prow / 8 != cur_row || pcol / 8 != cur_col) begin
			return -1;
		end
		return 8 * (prow % 8) + pcol % 8;
	endfunction

	function automatic logic in_t_region(input idct_pkg::sram_addr_t addr);
		return !$isunknown(addr) && addr >= t_base && addr < t_base + 18'd64;
	endfunction

	// --------------------
	// Reference model of T = S' x C scaled by 1/256
	task automatic compute_expected(input int row, input int col);
		idct_pkg::sample_t s [0:7][0:7];
		int acc;
		for (int r = 0; r < 8; r++) begin
			for (int k = 0; k < 8; k++) begin
				s[r][k] = idct_pkg::sample_t'(sram.mem[sample_addr(row, col, r, k)]);
			end
		end
		for (int r = 0; r < 8; r++) begin
			for (int j = 0; j < 8; j++) begin
				acc = 0;
				for (int k = 0; k < 8; k++) begin
					acc += int'(s[r][k]) * int'(idct_pkg::cos_coeff(3'(k), 3'(j)));
				end
				expected_t[8 * r + j] = idct_pkg::sram_data_t'(acc >>> 8);
			end
		end
	endtask

	// Random signed words over the whole sample plane
	task automatic fill_plane();
		for (int a = 0; a < idct_pkg::plane_width * plane_rows; a++) begin
			sram.mem[pre_idct_base + a] = idct_pkg::sram_data_t'($urandom);
		end
	endtask

	// Full scale samples of either sign
	task automatic fill_extreme(input int row, input int col);
		for (int r = 0; r < 8; r++) begin
			for (int k = 0; k < 8; k++) begin
				sram.mem[sample_addr(row, col, r, k)] = ($urandom & 1) ? 16'h7fff : 16'h8001;
			end
		end
	endtask

	// Compare the logged T writes of this request with the model
	task automatic compare_writes();
		int n;
		int idx;
		logic [63:0] written;
		idct_pkg::sram_addr_t a;
		idct_pkg::sram_data_t d;
		written = '0;
		n = sram.log_count - log_start;
		for (int i = 0; i < n && i < 64; i++) begin
			a = sram.log_addr[log_start + i];
			d = sram.log_data[log_start + i];
			// Stray addresses are already reported by the monitor
			if (in_t_region(a)) begin
				idx = int'(a - t_base);
				assert (!written[idx]) else begin
					$display("T word %0d was written twice in %s", idx, test_name);
					address_errors++;
				end
				written[idx] = 1'b1;
				assert (d === expected_t[idx]) else begin
					$display("** Error %s T[%0d][%0d] expected %04h actual %04h",
						test_name, idx / 8, idx % 8, expected_t[idx], d);
					value_errors++;
				end
			end
		end
		for (int i = 0; i < 64; i++) begin
			assert (written[i]) else begin
				$display("T[%0d][%0d] was never written in %s", i / 8, i % 8, test_name);
				value_errors++;
			end
		end
	endtask

	// One full four-phase request for block (row, col)
	task automatic run_block(input string name, input int row, input int col);
		int hold;
		compute_expected(row, col);
		test_name = name;
		cur_row = row;
		cur_col = col;
		@(posedge CLOCK_50_I);
		block_row <= idct_pkg::block_idx_t'(row);
		block_col <= idct_pkg::block_idx_t'(col);
		req <= 1'b1;
		@(negedge CLOCK_50_I);
		while (!ack) begin
			@(negedge CLOCK_50_I);
		end
		compare_writes();
		// Keep req up a while so ack has to hold
		hold = 1 + $urandom % 4;
		repeat (hold) @(posedge CLOCK_50_I);
		req <= 1'b0;
		while (ack) begin
			@(negedge CLOCK_50_I);
		end
	endtask

	task automatic finish_run();
		$display("Errors: value %0d, address %0d, handshake %0d, timeout %0d",
			value_errors, address_errors, handshake_errors, timeout_errors);
		if (value_errors + address_errors + handshake_errors + timeout_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// --------------------
	// Bus and handshake monitor on the falling edge
	always @(negedge CLOCK_50_I) begin
		if (Resetn) begin
			if (!req_seen && !req) begin
				assert (!ack && sram_cmd.we_n) else begin
					$display("ack or a write was active before the first request");
					handshake_errors++;
				end
			end
			// New request
			if (req && !req_prev) begin
				req_seen = 1'b1;
				read_count = 0;
				read_mask = '0;
				log_start = sram.log_count;
			end
			if (!sram_cmd.we_n) begin
				assert (req && !ack && in_t_region(sram_cmd.address)) else begin
					$display("Write to address %0d outside the T region in %s",
						sram_cmd.address, test_name);
					address_errors++;
				end
			end
			// Block reads start at the first address inside the block
			if (req && !ack && sram_cmd.we_n && read_count < 64) begin
				mon_idx = block_index(sram_cmd.address);
				if (read_count > 0 || mon_idx >= 0) begin
					assert (mon_idx >= 0) else begin
						$display("Read of address %0d outside block (%0d,%0d) in %s",
							sram_cmd.address, cur_row, cur_col, test_name);
						address_errors++;
					end
					if (mon_idx >= 0) begin
						assert (!read_mask[mon_idx]) else begin
							$display("Block sample %0d read twice in %s", mon_idx, test_name);
							address_errors++;
						end
						read_mask[mon_idx] = 1'b1;
					end
					read_count++;
				end
			end
			if (ack && !ack_prev) begin
				assert (req && sram.log_count - log_start == 64 && read_count == 64) else begin
					$display("ack rose after %0d T writes and %0d block reads in %s",
						sram.log_count - log_start, read_count, test_name);
					handshake_errors++;
				end
			end
			// Once high ack follows req with one cycle of delay
			if (ack_prev) begin
				assert (ack == req_prev) else begin
					$display("ack did not follow req one cycle later in %s", test_name);
					handshake_errors++;
				end
			end
		end
		req_prev = req;
		ack_prev = ack;
	end

	// Run limit
	always @(posedge CLOCK_50_I) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit) begin
			$display("Timeout after %0d cycles while running %s", cycle_limit, test_name);
			timeout_errors++;
			finish_run();
		end
	end

	// --------------------
	// Stimulus
	initial begin
		Resetn = 1'b0;
		req = 1'b0;
		block_row = '0;
		block_col = '0;
		void'($urandom(seed));
		fill_plane();
		repeat (3) @(posedge CLOCK_50_I);
		Resetn <= 1'b1;
		// Idle cycles checked by the monitor
		repeat (4) @(posedge CLOCK_50_I);
		for (int n = 0; n < num_random_blocks; n++) begin
			blk_row = $urandom % 30;
			blk_col = $urandom % 40;
			run_block($sformatf("random block %0d (%0d,%0d)", n, blk_row, blk_col),
				blk_row, blk_col);
		end
		// Plane corners at full scale
		fill_extreme(0, 0);
		run_block("corner block (0,0)", 0, 0);
		fill_extreme(29, 39);
		run_block("corner block (29,39)", 29, 39);
		repeat (4) @(posedge CLOCK_50_I);
		finish_run();
	end

endmodule

//--- project.f
source/idct_pkg.sv
source/block_fetch.sv
source/sample_buffer.sv
source/t_product_mac.sv
source/t_result_writer.sv
source/idct_controller.sv
source/idct_t_stage.sv
bench/sram_model.sv
bench/tb_idct_t_stage.sv
